// File: l2_console_pkg.sv
// L2 console shared definitions
`default_nettype none

package l2_console_pkg;

  // Bus widths
  localparam int ADDR_W = 16;  // Word address
  localparam int DATA_W = 32;  // Memory word
  localparam int CHAR_W = 8;   // Console character

  // Mailbox addresses, never stored in memory
  localparam logic [ADDR_W-1:0] STDOUT_ADDR = 16'hFFF4;  // Low byte goes to console
  localparam logic [ADDR_W-1:0] EXIT_ADDR   = 16'hFFF0;  // First nonzero write wins

  // Decoded destination of one access
  typedef enum logic [1:0] {
    SEL_MEM    = 2'd0,  // Backing array
    SEL_STDOUT = 2'd1,  // Console mailbox
    SEL_EXIT   = 2'd2,  // Exit code mailbox
    SEL_NONE   = 2'd3   // Out of range
  } mbox_sel_e;

  // Serializer FSM
  typedef enum logic [1:0] {
    TX_IDLE  = 2'd0,  // Line high, waiting for a character
    TX_START = 2'd1,  // Start bit, line low
    TX_DATA  = 2'd2,  // Data bits, LSB first
    TX_STOP  = 2'd3   // Stop bit, line high
  } tx_state_e;

endpackage

`default_nettype wire

// File: l2_sim_mem.sv
// Simulated L2 word memory
`timescale 1ns/1ps
`default_nettype none

module l2_sim_mem
  import l2_console_pkg::*;
#(
  parameter int MEM_WORDS = 256  // Depth, addresses at or above are out of range
) (
  input  wire logic              clk,
  input  wire logic              rst_i,
  input  wire logic              wr_en_i,      // One-cycle write strobe
  input  wire logic              rd_en_i,      // One-cycle read strobe
  input  wire logic [ADDR_W-1:0] addr_i,
  input  wire logic [DATA_W-1:0] wdata_i,
  output logic      [DATA_W-1:0] rdata_o,
  output logic                   rvalid_o,
  output logic                   char_push_o,  // Pulse to character FIFO
  output logic      [CHAR_W-1:0] char_data_o,
  output logic                   exit_valid_o, // Sticky until reset
  output logic      [DATA_W-1:0] exit_code_o
);

  localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

  // Backing store
  logic [DATA_W-1:0] mem [MEM_WORDS];

  // Request stage
  logic              wr_q;
  logic              rd_q;
  mbox_sel_e         sel_q;
  logic [IDX_W-1:0]  idx_q;
  logic [DATA_W-1:0] wdata_q;

  mbox_sel_e         sel_d;
  logic              char_ok;  // Stdout data in 1..255

  // Mailboxes take priority over the array
  function automatic mbox_sel_e decode(input logic [ADDR_W-1:0] a);
    if (a == STDOUT_ADDR) begin
      return SEL_STDOUT;
    end
    if (a == EXIT_ADDR) begin
      return SEL_EXIT;
    end
    if (32'(a) < MEM_WORDS) begin
      return SEL_MEM;
    end
    return SEL_NONE;
  endfunction

  assign sel_d   = decode(addr_i);
  assign char_ok = (wdata_q[DATA_W-1:CHAR_W] == '0) && (wdata_q[CHAR_W-1:0] != '0);

  // Capture the strobe and its payload
  always_ff @(posedge clk) begin
    if (rst_i) begin
      wr_q <= 1'b0;
      rd_q <= 1'b0;
    end else begin
      wr_q <= wr_en_i;
      rd_q <= rd_en_i;
    end
  end

  always_ff @(posedge clk) begin
    sel_q   <= sel_d;
    idx_q   <= addr_i[IDX_W-1:0];  // Only meaningful for SEL_MEM
    wdata_q <= wdata_i;
  end

  // Array write, out-of-range dropped
  always_ff @(posedge clk) begin
    if (wr_q && (sel_q == SEL_MEM)) begin
      mem[idx_q] <= wdata_q;
    end
  end

  // Read return, zero unless it hits the array
  always_ff @(posedge clk) begin
    if (rd_q) begin
      rdata_o <= (sel_q == SEL_MEM) ? mem[idx_q] : '0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      rvalid_o <= 1'b0;
    end else begin
      rvalid_o <= rd_q;
    end
  end

  // Console mailbox
  always_ff @(posedge clk) begin
    if (rst_i) begin
      char_push_o <= 1'b0;
    end else begin
      char_push_o <= wr_q && (sel_q == SEL_STDOUT) && char_ok;  // 0 and >255 ignored
    end
  end

  always_ff @(posedge clk) begin
    char_data_o <= wdata_q[CHAR_W-1:0];
  end

  // Exit mailbox, first nonzero code latched
  always_ff @(posedge clk) begin
    if (rst_i) begin
      exit_valid_o <= 1'b0;
      exit_code_o  <= '0;
    end else if (wr_q && (sel_q == SEL_EXIT) && (wdata_q != '0) && !exit_valid_o) begin
      exit_valid_o <= 1'b1;
      exit_code_o  <= wdata_q;
    end
  end

  // Requester must not mix strobes
  a_no_rd_wr: assert property (@(posedge clk) disable iff (rst_i)
    !(wr_en_i && rd_en_i));

  // Back-to-back returns only for back-to-back reads
  a_rvalid_src: assert property (@(posedge clk) disable iff (rst_i)
    rvalid_o && $past(rvalid_o) |-> $past(rd_en_i, 2) && $past(rd_en_i, 3));

endmodule

`default_nettype wire

// File: char_fifo.sv
// Console character FIFO
`timescale 1ns/1ps
`default_nettype none

module char_fifo
  import l2_console_pkg::*;
#(
  parameter int FIFO_DEPTH = 8  // Power of two
) (
  input  wire logic              clk,
  input  wire logic              rst_i,
  input  wire logic              push_i,
  input  wire logic [CHAR_W-1:0] push_data_i,
  input  wire logic              pop_i,
  output logic      [CHAR_W-1:0] head_o,     // Show-ahead
  output logic                   empty_o,
  output logic                   overflow_o  // Sticky
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = PTR_W + 1;

  // Pointer wrap relies on a power-of-two depth
  if (FIFO_DEPTH != (1 << PTR_W)) begin : g_depth_chk
    $error("char_fifo depth must be a power of two");
  end

  logic [CHAR_W-1:0] buf_q [FIFO_DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;

  logic full;
  logic push_ok;
  logic pop_ok;

  assign full    = (count == CNT_W'(FIFO_DEPTH));
  assign empty_o = (count == '0);
  assign head_o  = buf_q[rd_ptr];
  assign pop_ok  = pop_i && !empty_o;
  assign push_ok = push_i && (!full || pop_ok);  // Pop frees a slot this cycle

  // Storage
  always_ff @(posedge clk) begin
    if (push_ok) begin
      buf_q[wr_ptr] <= push_data_i;
    end
  end

  // Pointers and occupancy
  always_ff @(posedge clk) begin
    if (rst_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push_ok, pop_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Both or neither
      endcase
    end
  end

  // Dropped character flag
  always_ff @(posedge clk) begin
    if (rst_i) begin
      overflow_o <= 1'b0;
    end else if (push_i && !push_ok) begin
      overflow_o <= 1'b1;
    end
  end

  // Consumer only pops what is there
  a_no_pop_empty: assert property (@(posedge clk) disable iff (rst_i)
    pop_i |-> !empty_o);

endmodule

`default_nettype wire

// File: console_tx.sv
// 8N1 console serializer
`timescale 1ns/1ps
`default_nettype none

module console_tx
  import l2_console_pkg::*;
#(
  parameter int CLKS_PER_BIT = 4  // Cycles per bit time
) (
  input  wire logic              clk,
  input  wire logic              rst_i,
  input  wire logic              empty_i,
  input  wire logic [CHAR_W-1:0] head_i,
  output logic                   pop_o,   // One-cycle pulse
  output logic                   tx_o,    // Serial line, idles high
  output logic                   busy_o
);

  localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
  localparam int IDX_W = $clog2(CHAR_W);

  tx_state_e         state;
  logic [CNT_W-1:0]  bit_cnt;   // Cycles into current bit
  logic [IDX_W-1:0]  bit_idx;   // Data bit being sent
  logic [CHAR_W-1:0] shift_q;   // Remaining data bits
  logic              bit_end;

  assign bit_end = (bit_cnt == CNT_W'(CLKS_PER_BIT - 1));
  assign pop_o   = (state == TX_IDLE) && !empty_i;  // First idle cycle with data
  assign busy_o  = (state != TX_IDLE);

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state   <= TX_IDLE;
      tx_o    <= 1'b1;
      bit_cnt <= '0;
      bit_idx <= '0;
    end else begin
      case (state)
        TX_IDLE: begin
          bit_cnt <= '0;
          if (pop_o) begin
            state <= TX_START;
            tx_o  <= 1'b0;  // Start bit begins with the pop
          end
        end
        TX_START: begin
          if (bit_end) begin
            state   <= TX_DATA;
            tx_o    <= shift_q[0];
            bit_cnt <= '0;
            bit_idx <= '0;
          end else begin
            bit_cnt <= bit_cnt + 1'b1;
          end
        end
        TX_DATA: begin
          if (bit_end) begin
            bit_cnt <= '0;
            if (bit_idx == IDX_W'(CHAR_W - 1)) begin
              state <= TX_STOP;
              tx_o  <= 1'b1;  // Stop bit
            end else begin
              bit_idx <= bit_idx + 1'b1;
              tx_o    <= shift_q[1];  // Next LSB
            end
          end else begin
            bit_cnt <= bit_cnt + 1'b1;
          end
        end
        TX_STOP: begin
          if (bit_end) begin
            state   <= TX_IDLE;
            bit_cnt <= '0;
          end else begin
            bit_cnt <= bit_cnt + 1'b1;
          end
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

  // Frame data, latched on pop and shifted per bit
  always_ff @(posedge clk) begin
    if (pop_o) begin
      shift_q <= head_i;
    end else if ((state == TX_DATA) && bit_end) begin
      shift_q <= shift_q >> 1;
    end
  end

  // Line idles high
  a_idle_high: assert property (@(posedge clk) disable iff (rst_i)
    (state == TX_IDLE) |-> tx_o);

endmodule

`default_nettype wire

// File: l2_console_top.sv
// L2 memory with serial console
`timescale 1ns/1ps
`default_nettype none

module l2_console_top
  import l2_console_pkg::*;
#(
  parameter int MEM_WORDS    = 256,
  parameter int FIFO_DEPTH   = 8,
  parameter int CLKS_PER_BIT = 4
) (
  input  wire logic              clk,
  input  wire logic              rst_i,
  // Request side
  input  wire logic              wr_en_i,
  input  wire logic              rd_en_i,
  input  wire logic [ADDR_W-1:0] addr_i,
  input  wire logic [DATA_W-1:0] wdata_i,
  // Read return
  output logic      [DATA_W-1:0] rdata_o,
  output logic                   rvalid_o,
  // Console and exit
  output logic                   tx_o,
  output logic                   tx_busy_o,
  output logic                   overflow_o,
  output logic                   exit_valid_o,
  output logic      [DATA_W-1:0] exit_code_o
);

  logic              char_push;   // Memory to FIFO
  logic [CHAR_W-1:0] char_data;
  logic              fifo_empty;  // FIFO to serializer
  logic [CHAR_W-1:0] fifo_head;
  logic              char_pop;    // Serializer back to FIFO

  l2_sim_mem #(.MEM_WORDS(MEM_WORDS)) u_mem (
    .clk          (clk),
    .rst_i        (rst_i),
    .wr_en_i      (wr_en_i),
    .rd_en_i      (rd_en_i),
    .addr_i       (addr_i),
    .wdata_i      (wdata_i),
    .rdata_o      (rdata_o),
    .rvalid_o     (rvalid_o),
    .char_push_o  (char_push),
    .char_data_o  (char_data),
    .exit_valid_o (exit_valid_o),
    .exit_code_o  (exit_code_o)
  );

  char_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
    .clk         (clk),
    .rst_i       (rst_i),
    .push_i      (char_push),
    .push_data_i (char_data),
    .pop_i       (char_pop),
    .head_o      (fifo_head),
    .empty_o     (fifo_empty),
    .overflow_o  (overflow_o)
  );

  console_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_tx (
    .clk     (clk),
    .rst_i   (rst_i),
    .empty_i (fifo_empty),
    .head_i  (fifo_head),
    .pop_o   (char_pop),
    .tx_o    (tx_o),
    .busy_o  (tx_busy_o)
  );

endmodule

`default_nettype wire

// File: tb_l2_console_tests.svh
// L2 console directed tests
`ifndef TB_L2_CONSOLE_TESTS_SVH
`define TB_L2_CONSOLE_TESTS_SVH

  // Random words written to random in-range addresses and read back
  task automatic test_mem_readback();
    logic [31:0]       r;
    logic [DATA_W-1:0] d;
    logic [DATA_W-1:0] got;
    logic [ADDR_W-1:0] a;
    for (int i = 0; i < 16; i++) begin
      r = take_bits(TB_IDX_W);
      a = ADDR_W'(r);
      d = take_bits(DATA_W);
      mem_write(a, d);
      addr_list.push_back(int'(a));  // Repeats allowed since the last write wins
    end
    foreach (addr_list[i]) begin
      a = ADDR_W'(addr_list[i]);
      mem_read(a, got);
      check_word("rdata_o", expected_read(a), got);
    end
  endtask

  task automatic test_unmapped_reads();
    logic [ADDR_W-1:0] far_addr;
    logic [ADDR_W-1:0] alias_addr;
    logic [DATA_W-1:0] got;
    far_addr   = ADDR_W'(TB_MEM_WORDS + 5);
    alias_addr = ADDR_W'(5);  // Same low bits as far_addr
    mem_write(alias_addr, 32'h1234_5678);
    addr_list.push_back(int'(alias_addr));
    mem_write(far_addr, 32'hdead_beef);  // Must not land anywhere
    mem_read(far_addr, got);
    check_word("rdata_o", expected_read(far_addr), got);
    mem_read(STDOUT_ADDR, got);
    check_word("rdata_o", expected_read(STDOUT_ADDR), got);
    mem_read(EXIT_ADDR, got);
    check_word("rdata_o", expected_read(EXIT_ADDR), got);
    foreach (addr_list[i]) begin
      mem_read(ADDR_W'(addr_list[i]), got);
      check_word("rdata_o", expected_read(ADDR_W'(addr_list[i])), got);
    end
  endtask

  // One character at a time so the FIFO never fills
  task automatic test_console_string();
    string msg = "Hello";
    rx_q.delete();
    for (int i = 0; i < msg.len(); i++) begin
      put_char(msg[i]);
      wait_rx(i + 1);
    end
    drain_console();
    check_flag("tx_busy_o", 1'b0, tx_busy_o);
    check_tx_state("u_tx.state", TX_IDLE, uut.u_tx.state);
    check_flag("overflow_o", 1'b0, overflow_o);
    compare_rx(msg);
  endtask

  task automatic test_filtered_chars();
    rx_q.delete();
    put_char("A");
    mem_write(STDOUT_ADDR, DATA_W'(0));    // Zero is not a character
    mem_write(STDOUT_ADDR, DATA_W'(300));  // Above 255 and dropped
    put_char("B");
    wait_rx(2);
    drain_console();
    compare_rx("AB");
  endtask

  // Back-to-back pushes outrun the serializer
  task automatic test_overflow();
    string msg = "0123456789";
    rx_q.delete();
    for (int i = 0; i < msg.len(); i++) begin
      wr_en_i = 1'b1;
      addr_i  = STDOUT_ADDR;
      wdata_i = DATA_W'(msg[i]);
      @(negedge clk);
    end
    wr_en_i = 1'b0;
    drain_console();
    check_flag("overflow_o", 1'b1, overflow_o);
    if (rx_q.size() < TB_FIFO_DEPTH || rx_q.size() >= msg.len()) begin
      report_fault($sformatf("overflow run delivered %0d characters", rx_q.size()));
    end
    for (int i = 0; i < rx_q.size() && i < msg.len(); i++) begin
      check_char("rx char", msg[i], rx_q[i]);  // In-order prefix with no gaps
    end
  endtask

  task automatic test_exit_code();
    logic [ADDR_W-1:0] exit_alias;
    logic [DATA_W-1:0] w0;
    logic [DATA_W-1:0] code;
    logic [DATA_W-1:0] got;
    exit_alias = ADDR_W'(int'(EXIT_ADDR) % TB_MEM_WORDS);  // Array word under the mailbox
    w0 = take_bits(DATA_W);
    mem_write(exit_alias, w0);
    mem_write(EXIT_ADDR, '0);
    check_flag("exit_valid_o", 1'b0, exit_valid_o);  // Zero is no exit
    code = take_bits(DATA_W);
    code[0] = 1'b1;  // Keep it nonzero
    mem_write(EXIT_ADDR, code);
    check_flag("exit_valid_o", 1'b1, exit_valid_o);
    check_word("exit_code_o", code, exit_code_o);
    mem_write(EXIT_ADDR, code ^ 32'h0000_0100);  // Later codes ignored
    check_flag("exit_valid_o", 1'b1, exit_valid_o);
    check_word("exit_code_o", code, exit_code_o);
    mem_read(exit_alias, got);
    check_word("rdata_o", expected_read(exit_alias), got);
  endtask

`endif

// File: tb_l2_console.sv
// L2 console testbench
`timescale 1ns/1ps
`default_nettype none

module tb_l2_console
  import l2_console_pkg::*;
();

  localparam int TB_MEM_WORDS    = 64;
  localparam int TB_FIFO_DEPTH   = 4;
  localparam int TB_CLKS_PER_BIT = 4;
  localparam int TB_IDX_W        = $clog2(TB_MEM_WORDS);
  localparam int FRAME_CYCLES    = 10 * TB_CLKS_PER_BIT;              // Start, 8 data, stop
  localparam int WAIT_LIMIT      = (TB_FIFO_DEPTH + 2) * FRAME_CYCLES;  // Longest console wait
  // Reset 17, readback 80, unmapped 64, string 16, filter 14, overflow 16, exit 11
  localparam int REQ_CYCLES      = 218;
  localparam int CHARS_EXPECTED  = 17;  // 5 + 2 + 10
  localparam int TIMEOUT_CYCLES  = 2 * (REQ_CYCLES + CHARS_EXPECTED * FRAME_CYCLES);

  logic              clk = 1'b0;
  logic              rst_i;
  logic              wr_en_i;
  logic              rd_en_i;
  logic [ADDR_W-1:0] addr_i;
  logic [DATA_W-1:0] wdata_i;
  logic [DATA_W-1:0] rdata_o;
  logic              rvalid_o;
  logic              tx_o;
  logic              tx_busy_o;
  logic              overflow_o;
  logic              exit_valid_o;
  logic [DATA_W-1:0] exit_code_o;

  int                mismatch_cnt = 0;
  int                fault_cnt    = 0;
  int                cycle_cnt    = 0;
  logic [31:0]       lfsr_q;
  logic [CHAR_W-1:0] rx_q [$];           // Bytes seen on the serial line
  logic [DATA_W-1:0] model_mem [int];    // Expected array contents
  int                addr_list [$];      // In-range addresses written so far

  always #10 clk = ~clk;  // 20 ns period

  l2_console_top #(
    .MEM_WORDS    (TB_MEM_WORDS),
    .FIFO_DEPTH   (TB_FIFO_DEPTH),
    .CLKS_PER_BIT (TB_CLKS_PER_BIT)
  ) uut (
    .clk          (clk),
    .rst_i        (rst_i),
    .wr_en_i      (wr_en_i),
    .rd_en_i      (rd_en_i),
    .addr_i       (addr_i),
    .wdata_i      (wdata_i),
    .rdata_o      (rdata_o),
    .rvalid_o     (rvalid_o),
    .tx_o         (tx_o),
    .tx_busy_o    (tx_busy_o),
    .overflow_o   (overflow_o),
    .exit_valid_o (exit_valid_o),
    .exit_code_o  (exit_code_o)
  );

  // Fibonacci LFSR over x^32 + x^22 + x^2 + x + 1 stepping once per bit
  function automatic logic [31:0] take_bits(input int n);
    logic        fb;
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      v      = {v[30:0], fb};
    end
    return v;
  endfunction

  task automatic report_fault(input string msg);
    fault_cnt++;
    $display("Error at %0t ns: %s", $time, msg);
  endtask

  task automatic check_word(input string name, input logic [DATA_W-1:0] exp,
                            input logic [DATA_W-1:0] act);
    if (act !== exp) begin
      mismatch_cnt++;
      $display("Mismatch %s: expected 0x%h, got 0x%h", name, exp, act);
    end
  endtask

  task automatic check_char(input string name, input logic [CHAR_W-1:0] exp,
                            input logic [CHAR_W-1:0] act);
    if (act !== exp) begin
      mismatch_cnt++;
      $display("Mismatch %s: expected 0x%h, got 0x%h", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      mismatch_cnt++;
      $display("Mismatch %s: expected 0x%h, got 0x%h", name, exp, act);
    end
  endtask

  task automatic check_tx_state(input string name, input tx_state_e exp, input tx_state_e act);
    if (act !== exp) begin
      mismatch_cnt++;
      $display("Mismatch %s: expected 0x%h, got 0x%h", name, exp, act);
    end
  endtask

  // Classify an address with the mailboxes first
  function automatic mbox_sel_e classify_addr(input logic [ADDR_W-1:0] a);
    if (a == STDOUT_ADDR) return SEL_STDOUT;
    if (a == EXIT_ADDR) return SEL_EXIT;
    return (int'(a) < TB_MEM_WORDS) ? SEL_MEM : SEL_NONE;
  endfunction

  function automatic logic [DATA_W-1:0] expected_read(input logic [ADDR_W-1:0] a);
    if (classify_addr(a) == SEL_MEM && model_mem.exists(int'(a))) begin
      return model_mem[int'(a)];
    end
    return '0;  // Mailboxes and unmapped read as zero
  endfunction

  // Bus tasks enter and leave on a falling edge
  task automatic mem_write(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
    wr_en_i = 1'b1;
    addr_i  = a;
    wdata_i = d;
    @(negedge clk);
    wr_en_i = 1'b0;
    @(negedge clk);
    if (classify_addr(a) == SEL_MEM) model_mem[int'(a)] = d;
  endtask

  task automatic mem_read(input logic [ADDR_W-1:0] a, output logic [DATA_W-1:0] d);
    rd_en_i = 1'b1;
    addr_i  = a;
    @(negedge clk);
    rd_en_i = 1'b0;
    check_flag("rvalid_o", 1'b0, rvalid_o);  // Not yet
    @(negedge clk);
    check_flag("rvalid_o", 1'b1, rvalid_o);  // One cycle after the strobe
    d = rdata_o;
    @(negedge clk);
    check_flag("rvalid_o", 1'b0, rvalid_o);  // Single-cycle return
  endtask

  task automatic put_char(input logic [CHAR_W-1:0] c);
    mem_write(STDOUT_ADDR, DATA_W'(c));
  endtask

  task automatic wait_rx(input int n);
    int waited = 0;
    while (rx_q.size() < n && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (rx_q.size() < n) begin
      report_fault($sformatf("receiver got %0d of %0d characters", rx_q.size(), n));
    end
  endtask

  // Line counts as drained after six quiet cycles
  task automatic drain_console();
    int quiet  = 0;
    int waited = 0;
    while (quiet < 6 && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
      quiet = tx_busy_o ? 0 : quiet + 1;
    end
    if (quiet < 6) report_fault("transmitter never went idle");
  endtask

  task automatic compare_rx(input string exp);
    if (rx_q.size() != exp.len()) begin
      report_fault($sformatf("received %0d characters, expected %0d", rx_q.size(), exp.len()));
    end
    for (int i = 0; i < exp.len() && i < rx_q.size(); i++) begin
      check_char("rx char", exp[i], rx_q[i]);
    end
  endtask

  // Serial receiver sampling near mid-bit on falling edges
  always begin : serial_rx
    logic [CHAR_W-1:0] rx_byte;
    @(negedge clk);
    if (!rst_i && !tx_o) begin
      repeat (TB_CLKS_PER_BIT / 2) @(negedge clk);
      if (tx_o) report_fault("start bit did not hold low");
      for (int b = 0; b < CHAR_W; b++) begin
        repeat (TB_CLKS_PER_BIT) @(negedge clk);
        rx_byte = {tx_o, rx_byte[CHAR_W-1:1]};  // LSB arrives first
      end
      repeat (TB_CLKS_PER_BIT) @(negedge clk);
      if (!tx_o) report_fault("stop bit was low");
      rx_q.push_back(rx_byte);
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Run stopped after %0d cycles without finishing the tests", cycle_cnt);
      $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fault_cnt);
      $display("Result: FAILED");
      $finish;
    end
  end

`include "tb_l2_console_tests.svh"

  initial begin
    rst_i   = 1'b1;
    wr_en_i = 1'b0;
    rd_en_i = 1'b0;
    addr_i  = '0;
    wdata_i = '0;
    lfsr_q  = 32'hacca;
    repeat (16) @(negedge clk);  // 16 cycles of reset
    check_flag("tx_o", 1'b1, tx_o);
    check_flag("tx_busy_o", 1'b0, tx_busy_o);
    check_flag("rvalid_o", 1'b0, rvalid_o);
    check_flag("exit_valid_o", 1'b0, exit_valid_o);
    check_flag("overflow_o", 1'b0, overflow_o);
    check_tx_state("u_tx.state", TX_IDLE, uut.u_tx.state);
    rst_i = 1'b0;
    @(negedge clk);
    test_mem_readback();
    test_unmapped_reads();
    test_console_string();
    test_filtered_chars();
    test_overflow();
    test_exit_code();
    $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fault_cnt);
    if (mismatch_cnt == 0 && fault_cnt == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
+incdir+.
l2_console_pkg.sv
l2_sim_mem.sv
char_fifo.sv
console_tx.sv
l2_console_top.sv
tb_l2_console.sv

// File: run.sh
#!/bin/sh
# Build and run the L2 console testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f project.f \
  --top-module tb_l2_console -Mdir obj_dir -o sim_l2_console
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_l2_console > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
  exit 1
fi
exit 0
